/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_cic_top
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_cic_top.sv */
`timescale 1ns/100ps

module tb_cic_top;

    localparam int n_stages   = 2;    // stage count of the default filter.
    localparam int rate       = 2;    // output samples per input sample.
    localparam int wait_limit = 200;  // clk cycles allowed between two awaited events.
    localparam int smax       = (1 << (cic_pkg::in_w - 1)) - 1;  // largest signed sample.
    localparam int smin       = -(1 << (cic_pkg::in_w - 1));     // smallest signed sample.

    logic                     clk;
    logic                     rst;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [3:0]               paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;
    logic [cic_pkg::in_w-1:0] snd_in;
    logic                     in_take;
    logic [cic_pkg::in_w-1:0] snd_out;
    logic                     out_valid;

    logic                     quiet_chk;  // no take and no output expected.
    logic                     val_chk;    // every output must equal exp_out.
    logic                     rate_chk;   // pulse count per take is checked.
    logic                     rd_chk;     // read data must equal rd_exp.
    logic                     err_exp;    // the current transfer should fail.
    logic [cic_pkg::in_w-1:0] exp_out;    // settled output value.
    logic [31:0]              rd_exp;     // expected read data.
    logic                     sat_now;    // saturation mode as last written.
    logic [31:0]              rnd;        // raw random word.
    int                       gain_now;   // gain shift as last written.
    int                       ov_cnt;     // out_valid pulses since the last take.
    int                       errors;
    int                       tests;

    cic_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .snd_in    (snd_in),
        .in_take   (in_take),
        .snd_out   (snd_out),
        .out_valid (out_valid)
    );

    always #20 clk = ~clk;  // 40 ns period.

    initial begin
        #1_000_000;
        $display("run stopped by the watchdog after 1 ms of simulated time");
        $display("Test failed");
        $finish;
    end

    // counts outputs per input period, restarting on every take.
    always @(posedge clk) begin
        if (rst || in_take) begin
            ov_cnt <= 0;
        end else if (out_valid) begin
            ov_cnt <= ov_cnt + 1;
        end
    end

    // ****************************************
    // checks
    // ****************************************
    a_quiet : assert property (@(posedge clk) disable iff (rst)
        quiet_chk |-> !in_take && !out_valid)
        else begin
            errors++;
            $display("** Error: in_take = %h, out_valid = %h, expected 0 and 0",
                     $sampled(in_take), $sampled(out_valid));
        end

    a_level : assert property (@(posedge clk) disable iff (rst)
        (val_chk && out_valid) |-> snd_out == exp_out)
        else begin
            errors++;
            $display("** Error: snd_out = %h, expected %h", $sampled(snd_out), $sampled(exp_out));
        end

    a_rate : assert property (@(posedge clk) disable iff (rst)
        (rate_chk && in_take) |-> ov_cnt == rate)
        else begin
            errors++;
            $display("** Error: out_valid count = %h per in_take, expected %h",
                     $sampled(ov_cnt), rate);
        end

    a_read : assert property (@(posedge clk) disable iff (rst)
        (rd_chk && psel && penable && !pwrite) |-> prdata == rd_exp)
        else begin
            errors++;
            $display("** Error: prdata = %h, expected %h at offset %h",
                     $sampled(prdata), $sampled(rd_exp), $sampled(paddr));
        end

    a_slverr : assert property (@(posedge clk) disable iff (rst)
        pslverr == (psel && penable && err_exp))
        else begin
            errors++;
            $display("** Error: pslverr = %h, expected %h at offset %h",
                     $sampled(pslverr), $sampled(psel && penable && err_exp), $sampled(paddr));
        end

    // ****************************************
    // helpers
    // ****************************************
    function automatic logic unmapped(input logic [3:0] addr);
        return !(addr == cic_pkg::off_ctrl || addr == cic_pkg::off_shift ||
                 addr == cic_pkg::off_status || addr == cic_pkg::off_id);
    endfunction

    // normalization cancels the DC gain, so the settled output is the input times the gain.
    function automatic logic [cic_pkg::in_w-1:0] expect_level(
        input logic [cic_pkg::in_w-1:0] level
    );
        int lv;
        int res;
        lv  = int'($signed(level));
        res = lv * (1 << gain_now);
        if (sat_now && res > smax) begin
            res = smax;  // clipped at the top of the range.
        end else if (sat_now && res < smin) begin
            res = smin;
        end
        return res[cic_pkg::in_w-1:0];  // wrap mode keeps only the low bits.
    endfunction

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        int waited;
        waited  = 0;
        psel    = 1'b1;  // setup phase.
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        err_exp = unmapped(addr);
        @(negedge clk);
        penable = 1'b1;  // access phase lasts until pready.
        while (!pready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("APB transfer to offset %h never saw pready", addr);
            errors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        err_exp = 1'b0;
        rd_chk  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic read_reg(input logic [3:0] addr, input logic [31:0] value, input logic chk);
        rd_exp = value;
        rd_chk = chk;  // unmapped reads are only checked for pslverr.
        apb_xfer(1'b0, addr, 32'h0);
    endtask

    task automatic set_ctrl(input logic en, input logic sat);
        sat_now = sat;
        write_reg(cic_pkg::off_ctrl, {30'd0, sat, en});
    endtask

    task automatic set_gain(input int g);
        gain_now = g;
        write_reg(cic_pkg::off_shift, g);
    endtask

    // samples at the falling edge, where in_take and out_valid are stable.
    task automatic count_pulses(input logic takes, input int count);
        int seen;
        int idle;
        seen = 0;
        idle = 0;
        while (seen < count && idle < wait_limit) begin
            @(negedge clk);
            if (takes ? in_take : out_valid) begin
                seen++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (seen < count) begin
            $display("timed out waiting for %s pulses, saw %0d of %0d",
                     takes ? "in_take" : "out_valid", seen, count);
            errors++;
        end
    endtask

    // one take more than the settling window covers the output register.
    task automatic settle_level(input logic [cic_pkg::in_w-1:0] level);
        val_chk = 1'b0;
        snd_in  = level;
        exp_out = expect_level(level);
        count_pulses(1'b1, n_stages + 3);
        val_chk = 1'b1;
        count_pulses(1'b0, 2 * rate);
        @(negedge clk);  // lets the last counted output reach its check.
        val_chk = 1'b0;
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        $display("%s finished with %0d errors", name, errors - start);
    endtask

    // ****************************************
    // stimulus
    // ****************************************
    initial begin
        int start;
        clk       = 1'b0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 4'h0;
        pwdata    = 32'h0;
        snd_in    = '0;
        quiet_chk = 1'b0;
        val_chk   = 1'b0;
        rate_chk  = 1'b0;
        rd_chk    = 1'b0;
        err_exp   = 1'b0;
        exp_out   = '0;
        rd_exp    = 32'h0;
        sat_now   = 1'b1;  // matches the reset value of CTRL.
        gain_now  = 0;
        errors    = 0;
        tests     = 0;
        void'($urandom(32'h7d1efbf3));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start     = errors;
        quiet_chk = 1'b1;  // stopped until CTRL enables the filter.
        read_reg(cic_pkg::off_ctrl, 32'h2, 1'b1);
        read_reg(cic_pkg::off_shift, 32'h0, 1'b1);
        read_reg(cic_pkg::off_status, 32'h0, 1'b1);
        read_reg(cic_pkg::off_id, cic_pkg::id_value, 1'b1);
        report_test("reset state", start);

        start = errors;
        set_ctrl(1'b0, 1'b0);
        read_reg(cic_pkg::off_ctrl, 32'h0, 1'b1);
        set_ctrl(1'b0, 1'b1);
        read_reg(cic_pkg::off_ctrl, 32'h2, 1'b1);
        set_gain(3);
        read_reg(cic_pkg::off_shift, 32'h3, 1'b1);
        set_gain(0);
        read_reg(cic_pkg::off_shift, 32'h0, 1'b1);
        read_reg(4'h2, 32'h0, 1'b0);  // unmapped offsets answer with pslverr.
        write_reg(4'hE, 32'h1);
        write_reg(cic_pkg::off_status, 32'h1);
        read_reg(cic_pkg::off_status, 32'h0, 1'b1);
        report_test("APB decode", start);

        start     = errors;
        quiet_chk = 1'b0;
        snd_in    = 16'h1234;
        set_ctrl(1'b1, 1'b1);
        count_pulses(1'b1, 1);
        @(negedge clk);  // the first take has restarted the pulse count.
        rate_chk = 1'b1;
        settle_level(16'h1234);
        settle_level(16'hfc18);  // a negative level of -1000.
        report_test("rate and steady value", start);

        start = errors;
        repeat (4) begin
            rnd = $urandom;
            settle_level(rnd[cic_pkg::in_w-1:0]);
        end
        report_test("random DC levels", start);

        start = errors;
        set_gain(2);
        settle_level(16'd100);
        settle_level(16'h3000);  // four times this is beyond the top of the range.
        read_reg(cic_pkg::off_status, 32'h1, 1'b1);
        settle_level(16'hd000);
        set_ctrl(1'b1, 1'b0);
        settle_level(16'h3000);
        set_ctrl(1'b1, 1'b1);
        settle_level(16'd100);  // back in range before the flag is cleared.
        write_reg(cic_pkg::off_status, 32'h1);
        read_reg(cic_pkg::off_status, 32'h0, 1'b1);
        set_gain(0);
        report_test("gain and overflow", start);

        start    = errors;
        rate_chk = 1'b0;
        set_ctrl(1'b0, 1'b1);
        @(negedge clk);  // an out_valid from the last enable may still be in flight.
        quiet_chk = 1'b1;
        repeat (40) @(negedge clk);
        quiet_chk = 1'b0;
        snd_in    = '0;
        exp_out   = '0;
        val_chk   = 1'b1;  // silence is expected from the first output on.
        set_ctrl(1'b1, 1'b1);
        count_pulses(1'b0, 3 * rate);
        @(negedge clk);
        val_chk = 1'b0;
        report_test("disable and restart", start);

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/cic_pkg.sv
verilog/cic_cfg_if.sv
verilog/cic_reg_decode.sv
verilog/cic_cen_gen.sv
verilog/cic_comb.sv
verilog/cic_interp_execute.sv
verilog/cic_result_scale.sv
verilog/cic_top.sv
dv/tb_cic_top.sv

/* verilog/cic_cen_gen.sv */
`timescale 1ns/100ps

module cic_cen_gen #(
    parameter int RATE    = 2,
    parameter int DIV_OUT = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    output logic cen_in,
    output logic cen_out
);

    localparam int div_w = (DIV_OUT > 1) ? $clog2(DIV_OUT) : 1;  // divider counter width.
    localparam int ph_w  = (RATE > 1) ? $clog2(RATE) : 1;        // phase counter width.

    logic [div_w-1:0] div_cnt;  // clk cycles within one output period.
    logic [ph_w-1:0]  phase;    // output samples within one input period.

    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            div_cnt <= '0;  // held at zero so a restart begins a full period.
            phase   <= '0;
        end else begin
            div_cnt <= cen_out ? '0 : div_cnt + 1'b1;
            if (cen_out) begin
                phase <= (phase == ph_w'(RATE - 1)) ? '0 : phase + 1'b1;
            end
        end
    end

    assign cen_out = enable && (div_cnt == div_w'(DIV_OUT - 1));  // last clk of the period.
    assign cen_in  = cen_out && (phase == '0);                    // first of RATE outputs.

    // the divider leaves a gap of at least one clk between two output enables.
    a_out_spacing : assert property (@(posedge clk) disable iff (rst)
        cen_out |=> (DIV_OUT == 1) || !cen_out)
        else $error("cen_out pulsed in two clk cycles in a row");

endmodule

/* verilog/cic_cfg_if.sv */
`timescale 1ns/100ps

interface cic_cfg_if;

    logic                        enable;      // runs the filter and the rate enables.
    logic                        sat_en;      // saturate when high and wrap when low.
    logic [cic_pkg::gain_w-1:0]  gain_shift;  // left shift after normalization.
    logic                        ovf_clear;   // one-clk pulse that clears the overflow flag.
    logic                        ovf_seen;    // sticky overflow flag from the result stage.

    // the register block owns the configuration and reads the status back.
    modport cfg_src (output enable, sat_en, gain_shift, ovf_clear, input ovf_seen);

    // the execute stage only needs to know whether it runs.
    modport cfg_exec (input enable);

    // the result stage uses the full configuration and reports overflow.
    modport cfg_res (input enable, sat_en, gain_shift, ovf_clear, output ovf_seen);

endinterface

/* verilog/cic_comb.sv */
`timescale 1ns/100ps

module cic_comb #(
    parameter int M = 1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic signed [cic_pkg::calc_w-1:0] din,
    output logic signed [cic_pkg::calc_w-1:0] dout
);

    logic signed [cic_pkg::calc_w-1:0] dly [M];  // the last M inputs, newest first.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < M; i++) begin
                dly[i] <= '0;  // restart from silence.
            end
            dout <= '0;
        end else if (cen) begin
            dly[0] <= din;
            for (int i = 1; i < M; i++) begin
                dly[i] <= dly[i-1];  // shift the delay line by one sample.
            end
            dout <= din - dly[M-1];  // difference with the sample M steps back.
        end
    end

endmodule

/* verilog/cic_interp_execute.sv */
`timescale 1ns/100ps

module cic_interp_execute #(
    parameter int N    = 2,
    parameter int M    = 1,
    parameter int RATE = 2
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen_in,
    input  logic                              cen_out,
    input  logic signed [cic_pkg::in_w-1:0]   snd_in,
    cic_cfg_if.cfg_exec                       cfg,
    output logic signed [cic_pkg::calc_w-1:0] integ_out
);

    localparam int ext_w = cic_pkg::calc_w - cic_pkg::in_w;  // sign extension bits.
    localparam int ph_w  = (RATE > 1) ? $clog2(RATE) : 1;

    logic                              clr;                // clears all filter state.
    logic signed [cic_pkg::calc_w-1:0] comb_data [N+1];    // comb chain taps.
    logic signed [cic_pkg::calc_w-1:0] integ_data [N+1];   // integrator chain taps.
    logic signed [cic_pkg::calc_w-1:0] stuffed;            // zero-stuffed sample.
    logic [ph_w-1:0]                   phase;              // output slot within one input.

    assign clr = rst || !cfg.enable;  // a stopped filter forgets its history.

    // ****************************************
    // comb cascade at the input rate
    // ****************************************
    assign comb_data[0] = {{ext_w{snd_in[cic_pkg::in_w-1]}}, snd_in};

    for (genvar k = 0; k < N; k++) begin : g_comb
        cic_comb #(.M(M)) u_comb (
            .clk  (clk),
            .rst  (clr),
            .cen  (cen_in),
            .din  (comb_data[k]),
            .dout (comb_data[k+1])
        );
    end

    // ****************************************
    // zero stuffing at the output rate
    // ****************************************
    always_ff @(posedge clk) begin
        if (clr) begin
            stuffed <= '0;
            phase   <= '0;
        end else if (cen_out) begin
            stuffed <= cen_in ? comb_data[N] : '0;  // one real sample then RATE-1 zeros.
            phase   <= (phase == ph_w'(RATE - 1)) ? '0 : phase + 1'b1;
        end
    end

    // integrators wrap on purpose. The combs undo the wrap exactly.
    assign integ_data[0] = stuffed;

    for (genvar k = 0; k < N; k++) begin : g_integ
        logic signed [cic_pkg::calc_w-1:0] acc;  // running sum of this stage.

        always_ff @(posedge clk) begin
            if (clr) begin
                acc <= '0;
            end else if (cen_out) begin
                acc <= acc + integ_data[k];
            end
        end

        assign integ_data[k+1] = acc;
    end

    assign integ_out = integ_data[N];

    // the rate generator must line cen_in up with every RATE-th output slot.
    a_stuff_phase : assert property (@(posedge clk) disable iff (clr)
        cen_out |-> (cen_in == (phase == '0)))
        else $error("cen_in out of step with the zero-stuff phase");

endmodule

/* verilog/cic_pkg.sv */
package cic_pkg;

    // ****************************************
    // datapath widths
    // ****************************************
    localparam int in_w   = 16;  // audio sample width on both sides.
    localparam int calc_w = 20;  // accumulator width with headroom for the default filter.
    localparam int gain_w = 2;   // gain shift field gives a shift of 0 to 3.

    // the DC gain of the default filter is RATE^(N-1) * M^N = 2, so one right shift.
    localparam int norm_shift = 1;

    // ****************************************
    // APB register map
    // ****************************************
    localparam logic [3:0] off_ctrl   = 4'h0;  // enable in bit 0 and sat_en in bit 1.
    localparam logic [3:0] off_shift  = 4'h4;  // gain shift in the low bits.
    localparam logic [3:0] off_status = 4'h8;  // sticky overflow in bit 0.
    localparam logic [3:0] off_id     = 4'hC;  // read-only identification word.

    localparam logic [31:0] id_value = 32'h4349_4301;  // reads as "CIC" and version 1.

    // register select produced by the address decode.
    typedef enum logic [2:0] {
        sel_ctrl   = 3'd0,
        sel_shift  = 3'd1,
        sel_status = 3'd2,
        sel_id     = 3'd3,
        sel_none   = 3'd4
    } reg_sel_e;

endpackage

/* verilog/cic_reg_decode.sv */
`timescale 1ns/100ps

module cic_reg_decode (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    cic_cfg_if.cfg_src  cfg
);

    cic_pkg::reg_sel_e sel;  // register picked by paddr.

    logic                       access;      // APB access phase.
    logic                       wr_en;       // write access phase.
    logic                       ctrl_enable; // CTRL bit 0.
    logic                       ctrl_sat;    // CTRL bit 1.
    logic [cic_pkg::gain_w-1:0] gain_shift;  // SHIFT field.
    logic                       ovf_clear;   // pulse towards the result stage.

    // ****************************************
    // address decode
    // ****************************************
    always_comb begin
        case (paddr)
            cic_pkg::off_ctrl:   sel = cic_pkg::sel_ctrl;
            cic_pkg::off_shift:  sel = cic_pkg::sel_shift;
            cic_pkg::off_status: sel = cic_pkg::sel_status;
            cic_pkg::off_id:     sel = cic_pkg::sel_id;
            default:             sel = cic_pkg::sel_none;  // any other offset is unmapped.
        endcase
    end

    assign access  = psel && penable;               // no wait states so this is the last cycle.
    assign wr_en   = access && pwrite;              // writes land at the end of this cycle.
    assign pready  = 1'b1;                          // the block never stretches a transfer.
    assign pslverr = access && (sel == cic_pkg::sel_none);  // unmapped offsets fail.

    // ****************************************
    // configuration registers
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_enable <= 1'b0;  // the filter starts stopped.
            ctrl_sat    <= 1'b1;  // saturation is the safe default.
            gain_shift  <= '0;
            ovf_clear   <= 1'b0;
        end else begin
            ovf_clear <= wr_en && (sel == cic_pkg::sel_status) && pwdata[0];  // write 1 to clear.
            if (wr_en && (sel == cic_pkg::sel_ctrl)) begin
                ctrl_enable <= pwdata[0];
                ctrl_sat    <= pwdata[1];
            end
            if (wr_en && (sel == cic_pkg::sel_shift)) begin
                gain_shift <= pwdata[cic_pkg::gain_w-1:0];
            end
        end
    end

    assign cfg.enable     = ctrl_enable;
    assign cfg.sat_en     = ctrl_sat;
    assign cfg.gain_shift = gain_shift;
    assign cfg.ovf_clear  = ovf_clear;

    // read data is a plain mux of the registers.
    always_comb begin
        prdata = '0;
        case (sel)
            cic_pkg::sel_ctrl:   prdata = {30'd0, ctrl_sat, ctrl_enable};
            cic_pkg::sel_shift:  prdata = {{(32-cic_pkg::gain_w){1'b0}}, gain_shift};
            cic_pkg::sel_status: prdata = {31'd0, cfg.ovf_seen};
            cic_pkg::sel_id:     prdata = cic_pkg::id_value;
            default:             prdata = '0;  // unmapped reads return zero with an error.
        endcase
    end

    // an error response only closes a transfer that went through its setup cycle.
    a_slverr_access : assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable && $past(psel && !penable))
        else $error("pslverr raised outside an APB access phase");

endmodule

/* verilog/cic_result_scale.sv */
`timescale 1ns/100ps

module cic_result_scale #(
    parameter int norm_shift = 1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen_out,
    input  logic signed [cic_pkg::calc_w-1:0] integ_in,
    cic_cfg_if.cfg_res                        cfg,
    output logic signed [cic_pkg::in_w-1:0]   snd_out,
    output logic                              out_valid
);

    // room for the largest gain shift on top of the accumulator width.
    localparam int sc_w = cic_pkg::calc_w + (1 << cic_pkg::gain_w) - 1;
    localparam int in_w = cic_pkg::in_w;

    localparam logic signed [sc_w-1:0] max_val = {{(sc_w-in_w+1){1'b0}}, {(in_w-1){1'b1}}};
    localparam logic signed [sc_w-1:0] min_val = {{(sc_w-in_w+1){1'b1}}, {(in_w-1){1'b0}}};

    logic signed [cic_pkg::calc_w-1:0] normed;  // DC gain removed.
    logic signed [sc_w-1:0]            scaled;  // after the gain shift.
    logic                              over;    // above the largest sample.
    logic                              under;   // below the smallest sample.
    logic signed [in_w-1:0]            clipped; // value that goes out.
    logic                              ovf_seen;

    // ****************************************
    // normalize, gain and limit
    // ****************************************
    always_comb begin
        normed = integ_in >>> norm_shift;
        scaled = {{(sc_w-cic_pkg::calc_w){normed[cic_pkg::calc_w-1]}}, normed};
        scaled = scaled <<< cfg.gain_shift;
        over   = scaled > max_val;
        under  = scaled < min_val;
        if (cfg.sat_en && over) begin
            clipped = max_val[in_w-1:0];
        end else if (cfg.sat_en && under) begin
            clipped = min_val[in_w-1:0];
        end else begin
            clipped = scaled[in_w-1:0];  // wrap mode keeps the low bits.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_out   <= '0;
            out_valid <= 1'b0;
            ovf_seen  <= 1'b0;
        end else begin
            out_valid <= cen_out;  // one clk behind the rate enable.
            if (!cfg.enable) begin
                snd_out <= '0;  // silence while stopped.
            end else if (cen_out) begin
                snd_out <= clipped;
            end
            if (cfg.ovf_clear) begin
                ovf_seen <= 1'b0;
            end else if (cen_out && (over || under)) begin
                ovf_seen <= 1'b1;  // sticky until software clears it.
            end
        end
    end

    assign cfg.ovf_seen = ovf_seen;

    // a new output value is always flagged by out_valid, unless the filter was stopped.
    a_valid_timing : assert property (@(posedge clk) disable iff (rst)
        $changed(snd_out) |-> out_valid || !$past(cfg.enable))
        else $error("snd_out changed without an out_valid pulse");

endmodule

/* verilog/cic_top.sv */
`timescale 1ns/100ps

module cic_top #(
    parameter int N       = 2,
    parameter int M       = 1,
    parameter int RATE    = 2,
    parameter int DIV_OUT = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [3:0]                      paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic signed [cic_pkg::in_w-1:0] snd_in,
    output logic                            in_take,
    output logic signed [cic_pkg::in_w-1:0] snd_out,
    output logic                            out_valid
);

    logic                              cen_in;     // input-rate enable.
    logic                              cen_out;    // output-rate enable.
    logic signed [cic_pkg::calc_w-1:0] integ_out;  // full-width filter output.

    cic_cfg_if u_cfg ();

    cic_reg_decode u_reg_decode (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (u_cfg.cfg_src)
    );

    cic_cen_gen #(.RATE(RATE), .DIV_OUT(DIV_OUT)) u_cen_gen (
        .clk     (clk),
        .rst     (rst),
        .enable  (u_cfg.enable),
        .cen_in  (cen_in),
        .cen_out (cen_out)
    );

    assign in_take = cen_in;  // the source sees the take on the input-rate enable.

    cic_interp_execute #(.N(N), .M(M), .RATE(RATE)) u_execute (
        .clk       (clk),
        .rst       (rst),
        .cen_in    (cen_in),
        .cen_out   (cen_out),
        .snd_in    (snd_in),
        .cfg       (u_cfg.cfg_exec),
        .integ_out (integ_out)
    );

    cic_result_scale #(.norm_shift(cic_pkg::norm_shift)) u_result (
        .clk       (clk),
        .rst       (rst),
        .cen_out   (cen_out),
        .integ_in  (integ_out),
        .cfg       (u_cfg.cfg_res),
        .snd_out   (snd_out),
        .out_valid (out_valid)
    );

endmodule
